// ==== testbench/rot_golden.txt ====
# P kw2 cin_1 cols_1 blocks_1 xn_1 beats, then one W line per weight beat in hex
# R beats expected from that packet's replay
P 1 1 2 1 0 6
W 0a0b0c0d
W 1a1b1c1d
W 2a2b2c2d
W 3a3b3c3d
W 4a4b4c4d
W 5a5b5c5d
R 36
P 0 2 1 0 1 3
W c0ffee01
W c0ffee02
W c0ffee03
R 12
P 2 0 1 2 1 5
W 90817263
W a1b2c3d4
W 13579bdf
W 2468ace0
W f0e1d2c3
R 60
P 0 1 0 0 0 3
W 77665544
W 33221100
W deadbeef
R 2

// ==== src.f ====
logic/rot_cfg_pkg.sv
logic/rot_types_pkg.sv
logic/rot_header_decode.sv
logic/rot_bank_store.sv
logic/rot_replay_seq.sv
logic/axis_weight_rotator.sv
testbench/tb_weight_rotator.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_weight_rotator \
  -f src.f -o tb_weight_rotator &&
./obj_dir/tb_weight_rotator ||
{ echo "simulation did not pass"; exit 1; }

// ==== testbench/tb_weight_rotator.sv ====
`timescale 1ns/100ps

module tb_weight_rotator;
  import rot_cfg_pkg::*;
  import rot_types_pkg::*;

  localparam int TIMEOUT = 1000;

  logic aclk;
  logic aresetn;
  logic i_s_tvalid;
  logic o_s_tready;
  beat_t i_s_tdata;
  logic i_s_tlast;
  logic o_m_tvalid;
  logic i_m_tready;
  beat_t o_m_tdata;
  tuser_st o_m_tuser;
  logic o_m_tlast;
  logic o_len_err;

  // Packets and replay counts from the golden file
  header_st pkt_hdr[$];
  int pkt_beats[$];
  int pkt_off[$];
  beat_t words[$];
  int exp_count[$];

  // Expected beats of one replay
  beat_t exp_data[$];
  tuser_st exp_user[$];
  logic exp_last[$];

  // Master beat seen at the previous sample
  logic held;
  beat_t prev_data;
  tuser_st prev_user;
  logic prev_last;

  axis_weight_rotator i_dut (
    .aclk       (aclk),
    .aresetn    (aresetn),
    .i_s_tvalid (i_s_tvalid),
    .o_s_tready (o_s_tready),
    .i_s_tdata  (i_s_tdata),
    .i_s_tlast  (i_s_tlast),
    .o_m_tvalid (o_m_tvalid),
    .i_m_tready (i_m_tready),
    .o_m_tdata  (o_m_tdata),
    .o_m_tuser  (o_m_tuser),
    .o_m_tlast  (o_m_tlast),
    .o_len_err  (o_len_err)
  );

  initial begin
    aclk = 1'b0;
    forever #20 aclk = ~aclk;
  end

  task automatic abort_run(input string reason);
    $display("tests failed");
    $fatal(1, "%s", reason);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got %h exp %h", name, got, exp);
      abort_run("value mismatch");
    end
  endtask

  function automatic int word_count(input header_st h);
    return (2 * int'(h.kw2) + 1) * (int'(h.cin_1) + 1);
  endfunction

  task automatic load_golden();
    int fd;
    int code;
    string tag;
    string rest;
    int kw2_v;
    int cin_v;
    int cols_v;
    int blk_v;
    int xn_v;
    int nb_v;
    logic [31:0] word;
    header_st h;
    fd = $fopen("testbench/rot_golden.txt", "r");
    if (fd == 0)
      abort_run("cannot open testbench/rot_golden.txt");
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "P") begin
        code = $fscanf(fd, "%d %d %d %d %d %d", kw2_v, cin_v, cols_v, blk_v, xn_v, nb_v);
        if (code != 6)
          abort_run("malformed packet line in the golden file");
        h.kw2 = kw2_t'(kw2_v);
        h.cin_1 = cin_t'(cin_v);
        h.cols_1 = cols_t'(cols_v);
        h.blocks_1 = blk_t'(blk_v);
        h.xn_1 = xn_t'(xn_v);
        pkt_hdr.push_back(h);
        pkt_beats.push_back(nb_v);
        pkt_off.push_back(words.size());
      end else if (tag == "W") begin
        code = $fscanf(fd, "%h", word);
        if (code != 1)
          abort_run("malformed weight line in the golden file");
        words.push_back(word);
      end else if (tag == "R") begin
        code = $fscanf(fd, "%d", nb_v);
        if (code != 1)
          abort_run("malformed replay count in the golden file");
        exp_count.push_back(nb_v);
      end else begin
        abort_run("unknown record in the golden file");
      end
    end
    $fclose(fd);
    if (pkt_hdr.size() == 0 || exp_count.size() != pkt_hdr.size())
      abort_run("golden file needs one replay count per packet");
  endtask

  // Tap runs fastest, then channel, column, block and image
  task automatic build_model(input int p);
    header_st h;
    tuser_st u;
    int taps;
    int addr;
    h = pkt_hdr[p];
    taps = 2 * int'(h.kw2);
    exp_data.delete();
    exp_user.delete();
    exp_last.delete();
    for (int img = 0; img <= int'(h.xn_1); img++) begin
      for (int blk = 0; blk <= int'(h.blocks_1); blk++) begin
        for (int col = 0; col <= int'(h.cols_1); col++) begin
          for (int ch = 0; ch <= int'(h.cin_1); ch++) begin
            for (int tap = 0; tap <= taps; tap++) begin
              addr = tap * (int'(h.cin_1) + 1) + ch;
              u.kw2 = h.kw2;
              u.is_w_first_clk = (tap == 0) && (ch == 0) && (col == 0);
              u.is_cin_last = (tap == taps) && (ch == int'(h.cin_1));
              u.is_w_last = (col == int'(h.cols_1));
              exp_data.push_back(words[pkt_off[p] + addr]);
              exp_user.push_back(u);
              exp_last.push_back(1'b0);
            end
          end
        end
      end
    end
    exp_last[exp_last.size() - 1] = 1'b1;
  endtask

  // Called at 2 ns after a rising edge, returns at the same point
  task automatic send_beat(input beat_t data, input logic last);
    int waited;
    waited = 0;
    i_s_tvalid = 1'b1;
    i_s_tdata = data;
    i_s_tlast = last;
    @(negedge aclk);
    while (!o_s_tready) begin
      if (waited == TIMEOUT)
        abort_run("slave port never became ready");
      waited++;
      @(negedge aclk);
    end
    @(posedge aclk);
    #2;
    i_s_tvalid = 1'b0;
    i_s_tlast = 1'b0;
  endtask

  task automatic wait_len_err();
    int waited;
    waited = 0;
    while (!o_len_err) begin
      if (waited == TIMEOUT)
        abort_run("length error flag never rose after a packet of the wrong length");
      waited++;
      @(negedge aclk);
    end
  endtask

  task automatic send_packets();
    header_st h;
    beat_t hdr_beat;
    logic bad_seen;
    int n;
    bad_seen = 1'b0;
    @(posedge aclk);
    #2;
    for (int p = 0; p < pkt_hdr.size(); p++) begin
      h = pkt_hdr[p];
      n = pkt_beats[p];
      hdr_beat = '0;
      hdr_beat[$bits(header_st)-1:0] = h;
      send_beat(hdr_beat, 1'b0);
      for (int i = 0; i < n; i++)
        send_beat(words[pkt_off[p] + i], i == n - 1);
      @(negedge aclk);
      if (n != word_count(h)) begin
        wait_len_err();
        bad_seen = 1'b1;
      end else if (!bad_seen) begin
        check_value("o_len_err", 32'(o_len_err), 32'd0);
      end
      @(posedge aclk);
      #2;
    end
  endtask

  // Random tready each cycle, outputs sampled on the falling edge
  task automatic take_beat(output beat_t data, output tuser_st user, output logic last);
    int waited;
    logic got;
    waited = 0;
    got = 1'b0;
    while (!got) begin
      if (waited == TIMEOUT)
        abort_run("no output beat arrived in time");
      waited++;
      @(posedge aclk);
      #2;
      i_m_tready = ($urandom % 4) != 0;
      @(negedge aclk);
      if (held) begin
        check_value("o_m_tvalid", 32'(o_m_tvalid), 32'd1);
        check_value("o_m_tdata", o_m_tdata, prev_data);
        check_value("o_m_tuser", 32'(o_m_tuser), 32'(prev_user));
        check_value("o_m_tlast", 32'(o_m_tlast), 32'(prev_last));
      end
      held = o_m_tvalid && !i_m_tready;
      prev_data = o_m_tdata;
      prev_user = o_m_tuser;
      prev_last = o_m_tlast;
      if (o_m_tvalid && i_m_tready) begin
        data = o_m_tdata;
        user = o_m_tuser;
        last = o_m_tlast;
        got = 1'b1;
      end
    end
  endtask

  task automatic check_replays();
    beat_t data;
    tuser_st user;
    logic last;
    for (int p = 0; p < pkt_hdr.size(); p++) begin
      build_model(p);
      check_value("beat_count", 32'(exp_data.size()), 32'(exp_count[p]));
      for (int n = 0; n < exp_data.size(); n++) begin
        take_beat(data, user, last);
        check_value("tdata", data, exp_data[n]);
        check_value("tuser", 32'(user), 32'(exp_user[n]));
        check_value("tlast", 32'(last), 32'(exp_last[n]));
      end
    end
  endtask

  initial begin
    aresetn = 1'b0;
    i_s_tvalid = 1'b0;
    i_s_tdata = '0;
    i_s_tlast = 1'b0;
    i_m_tready = 1'b0;
    held = 1'b0;
    void'($urandom(85));
    load_golden();
    repeat (2) @(posedge aclk);
    @(negedge aclk);
    check_value("o_m_tvalid", 32'(o_m_tvalid), 32'd0);
    check_value("o_s_tready", 32'(o_s_tready), 32'd0);
    check_value("o_len_err", 32'(o_len_err), 32'd0);
    @(posedge aclk);
    #2;
    aresetn = 1'b1;
    @(negedge aclk);
    check_value("o_m_tvalid", 32'(o_m_tvalid), 32'd0);
    check_value("o_s_tready", 32'(o_s_tready), 32'd0);
    check_value("o_len_err", 32'(o_len_err), 32'd0);
    fork
      send_packets();
      check_replays();
    join
    // No beat left over once every replay is consumed
    @(posedge aclk);
    #2;
    i_m_tready = 1'b1;
    repeat (8) begin
      @(negedge aclk);
      check_value("o_m_tvalid", 32'(o_m_tvalid), 32'd0);
    end
    check_value("o_len_err", 32'(o_len_err), 32'd1);
    $display("all tests passed");
    $finish;
  end

endmodule

// ==== logic/axis_weight_rotator.sv ====
`timescale 1ns/100ps

module axis_weight_rotator (
  input  logic                   aclk,
  input  logic                   aresetn,
  input  logic                   i_s_tvalid,
  output logic                   o_s_tready,
  input  rot_types_pkg::beat_t   i_s_tdata,
  input  logic                   i_s_tlast,
  output logic                   o_m_tvalid,
  input  logic                   i_m_tready,
  output rot_types_pkg::beat_t   o_m_tdata,
  output rot_types_pkg::tuser_st o_m_tuser,
  output logic                   o_m_tlast,
  output logic                   o_len_err
);
  import rot_types_pkg::*;

  logic hdr_stb;
  logic hdr_phase;
  bank_req_st req;
  logic rd_start;
  bank_req_st rd_req;
  addr_t rd_addr;
  logic last_beat;
  logic adv;

  rot_header_decode u_decode (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_s_tvalid  (i_s_tvalid),
    .i_s_tready  (o_s_tready),
    .i_s_tdata   (i_s_tdata),
    .i_s_tlast   (i_s_tlast),
    .i_hdr_phase (hdr_phase),
    .o_hdr_stb   (hdr_stb),
    .o_req       (req),
    .o_len_err   (o_len_err)
  );

  rot_bank_store u_store (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_s_tvalid  (i_s_tvalid),
    .i_s_tdata   (i_s_tdata),
    .i_s_tlast   (i_s_tlast),
    .i_hdr_stb   (hdr_stb),
    .i_req       (req),
    .i_addr      (rd_addr),
    .i_last_beat (last_beat),
    .i_m_tready  (i_m_tready),
    .o_s_tready  (o_s_tready),
    .o_hdr_phase (hdr_phase),
    .o_rd_start  (rd_start),
    .o_rd_req    (rd_req),
    .o_adv       (adv),
    .o_m_tvalid  (o_m_tvalid),
    .o_m_tdata   (o_m_tdata),
    .o_m_tlast   (o_m_tlast)
  );

  rot_replay_seq u_seq (
    .aclk        (aclk),
    .aresetn     (aresetn),
    .i_rd_start  (rd_start),
    .i_rd_req    (rd_req),
    .i_adv       (adv),
    .i_m_tready  (i_m_tready),
    .i_m_tvalid  (o_m_tvalid),
    .o_addr      (rd_addr),
    .o_last_beat (last_beat),
    .o_m_tuser   (o_m_tuser)
  );

endmodule

// ==== logic/rot_replay_seq.sv ====
`timescale 1ns/100ps

module rot_replay_seq (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      i_rd_start,
  input  rot_types_pkg::bank_req_st i_rd_req,
  input  logic                      i_adv,
  input  logic                      i_m_tready,
  input  logic                      i_m_tvalid,
  output rot_types_pkg::addr_t      o_addr,
  output logic                      o_last_beat,
  output rot_types_pkg::tuser_st    o_m_tuser
);
  import rot_cfg_pkg::*;
  import rot_types_pkg::*;

  bank_req_st req;
  logic [KW2_W:0] tap;
  cin_t ch;
  cols_t col;
  blk_t blk;
  xn_t img;
  logic l_tap;
  logic l_ch;
  logic l_col;
  logic l_blk;
  logic l_img;
  tuser_st flags;
  tuser_st q [2];
  logic q_wr_ptr;
  logic q_rd_ptr;

  assign l_tap = (tap == {req.hdr.kw2, 1'b0});
  assign l_ch = (ch == req.hdr.cin_1);
  assign l_col = (col == req.hdr.cols_1);
  assign l_blk = (blk == req.hdr.blocks_1);
  assign l_img = (img == req.hdr.xn_1);
  assign o_last_beat = l_tap && l_ch && l_col && l_blk && l_img;

  // Same kernel words again for every column
  assign o_addr = addr_t'(tap) * (addr_t'(req.hdr.cin_1) + addr_t'(1)) + addr_t'(ch);

  always_ff @(posedge aclk) begin
    if (i_rd_start)
      req <= i_rd_req;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn || i_rd_start) begin
      tap <= '0;
      ch <= '0;
      col <= '0;
      blk <= '0;
      img <= '0;
    end else if (i_adv) begin
      tap <= l_tap ? '0 : tap + 1'b1;
      if (l_tap) begin
        ch <= l_ch ? '0 : ch + 1'b1;
        if (l_ch) begin
          col <= l_col ? '0 : col + 1'b1;
          if (l_col) begin
            blk <= l_blk ? '0 : blk + 1'b1;
            if (l_blk)
              img <= l_img ? '0 : img + 1'b1;
          end
        end
      end
    end
  end

  assign flags.kw2 = req.hdr.kw2;
  assign flags.is_w_first_clk = (tap == '0) && (ch == '0) && (col == '0);
  assign flags.is_cin_last = l_tap && l_ch;
  assign flags.is_w_last = l_col;

  // Flags wait here until their beat leaves the skid register
  always_ff @(posedge aclk) begin
    if (i_adv)
      q[q_wr_ptr] <= flags;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      q_wr_ptr <= 1'b0;
      q_rd_ptr <= 1'b0;
    end else begin
      if (i_adv)
        q_wr_ptr <= ~q_wr_ptr;
      if (i_m_tvalid && i_m_tready)
        q_rd_ptr <= ~q_rd_ptr;
    end
  end

  assign o_m_tuser = q[q_rd_ptr];

endmodule

// ==== logic/rot_bank_store.sv ====
`timescale 1ns/100ps

module rot_bank_store (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      i_s_tvalid,
  input  rot_types_pkg::beat_t      i_s_tdata,
  input  logic                      i_s_tlast,
  input  logic                      i_hdr_stb,
  input  rot_types_pkg::bank_req_st i_req,
  input  rot_types_pkg::addr_t      i_addr,
  input  logic                      i_last_beat,
  input  logic                      i_m_tready,
  output logic                      o_s_tready,
  output logic                      o_hdr_phase,
  output logic                      o_rd_start,
  output rot_types_pkg::bank_req_st o_rd_req,
  output logic                      o_adv,
  output logic                      o_m_tvalid,
  output rot_types_pkg::beat_t      o_m_tdata,
  output logic                      o_m_tlast
);
  import rot_cfg_pkg::*;
  import rot_types_pkg::*;

  wr_state_e wr_state;
  rd_state_e rd_state;
  logic wr_bank;
  logic rd_bank;
  logic [1:0] done_write;
  logic [1:0] done_read;
  bank_req_st req_q [2];
  beat_t mem [2][DEPTH];
  logic [ADDR_W:0] wr_cnt;
  logic wr_en;
  logic rd_go;
  beat_t rd_data;
  logic rd_last;
  logic rd_valid;
  beat_t skid_data [2];
  logic skid_last [2];
  logic skid_wr_ptr;
  logic skid_rd_ptr;
  logic [1:0] skid_cnt;
  logic [1:0] occ_next;
  logic m_hs;

  assign o_hdr_phase = (wr_state == W_HEADER);
  assign o_s_tready = (wr_state == W_HEADER) || (wr_state == W_WRITE);
  assign wr_en = i_s_tvalid && (wr_state == W_WRITE);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_state <= W_IDLE;
      wr_bank <= 1'b0;
    end else begin
      unique case (wr_state)
        W_IDLE:   if (done_read[wr_bank]) wr_state <= W_HEADER;
        W_HEADER: if (i_hdr_stb) wr_state <= W_WRITE;
        W_WRITE:  if (wr_en && i_s_tlast) wr_state <= W_SWITCH;
        W_SWITCH: begin
          wr_state <= W_IDLE;
          wr_bank <= ~wr_bank;
        end
        default:  wr_state <= W_IDLE;
      endcase
    end
  end

  assign rd_go = (rd_state == R_IDLE) && done_write[rd_bank];
  assign o_rd_start = rd_go;
  assign o_rd_req = req_q[rd_bank];

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_state <= R_IDLE;
      rd_bank <= 1'b0;
    end else begin
      unique case (rd_state)
        R_IDLE:   if (rd_go) rd_state <= R_READ;
        R_READ:   if (o_adv && i_last_beat) rd_state <= R_SWITCH;
        R_SWITCH: begin
          rd_state <= R_IDLE;
          rd_bank <= ~rd_bank;
        end
        default:  rd_state <= R_IDLE;
      endcase
    end
  end

  // Handoff between writer and reader per bank
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      done_write <= 2'b00;
      done_read <= 2'b11;
    end else begin
      if (wr_state == W_IDLE && done_read[wr_bank])
        done_write[wr_bank] <= 1'b0;
      if (wr_state == W_SWITCH) begin
        done_write[wr_bank] <= 1'b1;
        done_read[wr_bank] <= 1'b0;
      end
      if (rd_state == R_SWITCH)
        done_read[rd_bank] <= 1'b1;
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn)
      wr_cnt <= '0;
    else if (i_hdr_stb)
      wr_cnt <= '0;
    else if (wr_en)
      wr_cnt <= wr_cnt + 1'b1;
  end

  always_ff @(posedge aclk) begin
    if (wr_en)
      mem[wr_bank][wr_cnt[ADDR_W-1:0]] <= i_s_tdata;
    if (i_hdr_stb)
      req_q[wr_bank] <= i_req;
    if (o_adv) begin
      rd_data <= mem[rd_bank][i_addr];
      rd_last <= i_last_beat;
    end
    if (rd_valid) begin
      skid_data[skid_wr_ptr] <= rd_data;
      skid_last[skid_wr_ptr] <= rd_last;
    end
  end

  // Issue only if the beat in flight still finds a free skid slot
  assign m_hs = o_m_tvalid && i_m_tready;
  assign occ_next = skid_cnt + {1'b0, rd_valid} - {1'b0, m_hs};
  assign o_adv = (rd_state == R_READ) && (occ_next <= 2'd1);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rd_valid <= 1'b0;
      skid_wr_ptr <= 1'b0;
      skid_rd_ptr <= 1'b0;
      skid_cnt <= 2'd0;
    end else begin
      rd_valid <= o_adv;
      skid_cnt <= occ_next;
      if (rd_valid)
        skid_wr_ptr <= ~skid_wr_ptr;
      if (m_hs)
        skid_rd_ptr <= ~skid_rd_ptr;
    end
  end

  assign o_m_tvalid = (skid_cnt != 2'd0);
  assign o_m_tdata = skid_data[skid_rd_ptr];
  assign o_m_tlast = skid_last[skid_rd_ptr];

  a_bank_apart: assert property (@(posedge aclk) disable iff (!aresetn)
    (wr_state != W_IDLE && rd_state != R_IDLE) |-> (wr_bank != rd_bank));

  a_wr_in_range: assert property (@(posedge aclk) disable iff (!aresetn)
    wr_en |-> (wr_cnt < DEPTH));

endmodule

// ==== logic/rot_header_decode.sv ====
`timescale 1ns/100ps

module rot_header_decode (
  input  logic                      aclk,
  input  logic                      aresetn,
  input  logic                      i_s_tvalid,
  input  logic                      i_s_tready,
  input  rot_types_pkg::beat_t      i_s_tdata,
  input  logic                      i_s_tlast,
  input  logic                      i_hdr_phase,
  output logic                      o_hdr_stb,
  output rot_types_pkg::bank_req_st o_req,
  output logic                      o_len_err
);
  import rot_cfg_pkg::*;
  import rot_types_pkg::*;

  header_st hdr;
  logic [ADDR_W:0] n_words;
  logic [ADDR_W:0] beat_cnt;
  logic [ADDR_W:0] last_idx;
  addr_t addr_max_q;
  logic s_hs;
  logic w_hs;
  logic bad_beat;

  assign s_hs = i_s_tvalid && i_s_tready;
  assign o_hdr_stb = s_hs && i_hdr_phase;
  assign w_hs = s_hs && !i_hdr_phase;

  assign hdr = header_st'(i_s_tdata[$bits(header_st)-1:0]);

  // Kernel taps times input channels
  assign n_words = {hdr.kw2, 1'b1} * (hdr.cin_1 + 1'b1);

  assign o_req.hdr = hdr;
  assign o_req.addr_max = addr_t'(n_words - 1'b1);

  // Weight beat index must end exactly on addr_max
  assign last_idx = {1'b0, addr_max_q};
  assign bad_beat = (beat_cnt > last_idx) || (i_s_tlast && (beat_cnt != last_idx));

  always_ff @(posedge aclk) begin
    if (o_hdr_stb)
      addr_max_q <= o_req.addr_max;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      beat_cnt <= '0;
      o_len_err <= 1'b0;
    end else begin
      if (o_hdr_stb)
        beat_cnt <= '0;
      else if (w_hs && !(&beat_cnt))
        beat_cnt <= beat_cnt + 1'b1;
      // Sticky until reset
      if (w_hs && bad_beat)
        o_len_err <= 1'b1;
    end
  end

  // Weight beats beyond one bank come only after a length error
  a_fits_bank: assert property (@(posedge aclk) disable iff (!aresetn)
    w_hs |-> ((beat_cnt < DEPTH) || o_len_err));

endmodule

// ==== logic/rot_types_pkg.sv ====
package rot_types_pkg;
  import rot_cfg_pkg::*;

  typedef logic [M_W-1:0] beat_t;
  typedef logic [ADDR_W-1:0] addr_t;

  typedef logic [KW2_W-1:0] kw2_t;
  typedef logic [CI_W-1:0] cin_t;
  typedef logic [XW_W-1:0] cols_t;
  typedef logic [BLK_W-1:0] blk_t;
  typedef logic [XN_W-1:0] xn_t;

  // Low bits of the header beat, xn_1 at bit 0
  typedef struct packed {
    kw2_t  kw2;
    cin_t  cin_1;
    cols_t cols_1;
    blk_t  blocks_1;
    xn_t   xn_1;
  } header_st;

  typedef struct packed {
    header_st hdr;
    addr_t    addr_max;
  } bank_req_st;

  typedef struct packed {
    kw2_t kw2;
    logic is_w_first_clk;
    logic is_cin_last;
    logic is_w_last;
  } tuser_st;

  typedef enum logic [1:0] {W_IDLE, W_HEADER, W_WRITE, W_SWITCH} wr_state_e;

  typedef enum logic [1:0] {R_IDLE, R_READ, R_SWITCH} rd_state_e;

endpackage

// ==== logic/rot_cfg_pkg.sv ====
package rot_cfg_pkg;

  // Output row of weights
  localparam int COLS = 4;
  localparam int WORD_W = 8;
  localparam int M_W = COLS * WORD_W;

  // Largest loop bounds the header may carry
  localparam int KW2_MAX = 3;
  localparam int CI_MAX = 8;
  localparam int XW_MAX = 32;
  localparam int BLK_MAX = 4;
  localparam int XN_MAX = 4;

  // Header field widths, stored as value minus one except kw2
  localparam int KW2_W = $clog2(KW2_MAX + 1);
  localparam int CI_W = $clog2(CI_MAX);
  localparam int XW_W = $clog2(XW_MAX);
  localparam int BLK_W = $clog2(BLK_MAX);
  localparam int XN_W = $clog2(XN_MAX);

  // Words per bank, two banks in total
  localparam int DEPTH = 64;
  localparam int ADDR_W = $clog2(DEPTH);

endpackage
